//--- Makefile
# Verilator build and run for the core memory fabric

VERILATOR ?= verilator
TOP ?= tb_soc_mem
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
ERROR_LIMIT ?= 100
JOBS ?= 0
VFLAGS ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "Verification passed" $(LOG); then echo "PASS"; \
	else echo "FAIL, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
hw/soc_mem_pkg.sv
hw/mem_req_if.sv
hw/addr_region_decode.sv
hw/tcm_ram.sv
hw/data_axil_bridge.sv
hw/resp_merge.sv
hw/soc_mem_top.sv
testbench/tb_clock_gen.sv
testbench/soc_mem_assert.sv
testbench/tb_soc_mem.sv

//--- hw/addr_region_decode.sv
`timescale 1ns/1ns

module addr_region_decode import soc_mem_pkg::*; (
	input logic instr_req_i,
	input addr_t instr_addr_i,
	input logic data_req_i,
	input logic data_we_i,
	input addr_t data_addr_i,
	input be_t data_be_i,
	input word_t data_wdata_i,
	input logic bridge_idle_i,
	output logic instr_gnt_o,
	output logic data_gnt_o,
	output logic fetch_miss_o,
	mem_req_if.master tcm_i,
	mem_req_if.master tcm_d,
	mem_req_if.master ext_d
);

	logic instr_hit;
	logic data_hit;

	assign instr_hit = (region_t'(instr_addr_i[31:28]) == TCM_REGION);
	assign data_hit = (region_t'(data_addr_i[31:28]) == TCM_REGION);

	// Fetch port is read only
	assign tcm_i.req = instr_req_i & instr_hit;
	assign tcm_i.we = 1'b0;
	assign tcm_i.be = 4'hf;
	assign tcm_i.addr = instr_addr_i;
	assign tcm_i.wdata = '0;

	// No outside path for fetches, accept at once and flag
	assign fetch_miss_o = instr_req_i & ~instr_hit;
	assign instr_gnt_o = instr_hit ? (instr_req_i & tcm_i.gnt) : instr_req_i;

	// Busy bridge holds off every data request to keep order
	assign tcm_d.req = data_req_i & data_hit & bridge_idle_i;
	assign tcm_d.we = data_we_i;
	assign tcm_d.be = data_be_i;
	assign tcm_d.addr = data_addr_i;
	assign tcm_d.wdata = data_wdata_i;

	assign ext_d.req = data_req_i & ~data_hit & bridge_idle_i;
	assign ext_d.we = data_we_i;
	assign ext_d.be = data_be_i;
	assign ext_d.addr = data_addr_i;
	assign ext_d.wdata = data_wdata_i;

	assign data_gnt_o = data_hit ? (tcm_d.req & tcm_d.gnt) : (ext_d.req & ext_d.gnt);

endmodule

//--- hw/data_axil_bridge.sv
`timescale 1ns/1ns

module data_axil_bridge import soc_mem_pkg::*; (
	input logic clk_i,
	input logic resetn,
	mem_req_if.slave ext_d,
	output logic bridge_idle_o,
	output logic m_axi_awvalid_o,
	input logic m_axi_awready_i,
	output addr_t m_axi_awaddr_o,
	output logic m_axi_wvalid_o,
	input logic m_axi_wready_i,
	output word_t m_axi_wdata_o,
	output be_t m_axi_wstrb_o,
	input logic m_axi_bvalid_i,
	output logic m_axi_bready_o,
	input axi_resp_t m_axi_bresp_i,
	output logic m_axi_arvalid_o,
	input logic m_axi_arready_i,
	output addr_t m_axi_araddr_o,
	input logic m_axi_rvalid_i,
	output logic m_axi_rready_o,
	input word_t m_axi_rdata_i,
	input axi_resp_t m_axi_rresp_i
);

	bridge_state_t state_q;

	logic awvalid_q;
	logic wvalid_q;
	logic bready_q;
	logic arvalid_q;
	logic rready_q;
	logic rvalid_q;
	logic err_q;

	addr_t addr_q;
	word_t wdata_q;
	be_t be_q;
	word_t rdata_q;

	assign bridge_idle_o = (state_q == IDLE);
	assign ext_d.gnt = (state_q == IDLE);

	always_ff @(posedge clk_i)
	begin
		if (!resetn)
		begin
			state_q <= IDLE;
			awvalid_q <= 1'b0;
			wvalid_q <= 1'b0;
			bready_q <= 1'b0;
			arvalid_q <= 1'b0;
			rready_q <= 1'b0;
			rvalid_q <= 1'b0;
			err_q <= 1'b0;
		end
		else
		begin
			rvalid_q <= 1'b0;
			err_q <= 1'b0;
			case (state_q)
			IDLE:
			begin
				if (ext_d.req && ext_d.we)
				begin
					state_q <= WRITE_ADDR_DATA;
					awvalid_q <= 1'b1;
					wvalid_q <= 1'b1;
				end
				else if (ext_d.req)
				begin
					state_q <= READ_ADDR;
					arvalid_q <= 1'b1;
				end
			end
			WRITE_ADDR_DATA:
			begin
				// AW and W may complete in either order
				if (m_axi_awready_i)
					awvalid_q <= 1'b0;
				if (m_axi_wready_i)
					wvalid_q <= 1'b0;
				if ((!awvalid_q || m_axi_awready_i) && (!wvalid_q || m_axi_wready_i))
				begin
					state_q <= WRITE_RESP;
					bready_q <= 1'b1;
				end
			end
			WRITE_RESP:
			begin
				if (m_axi_bvalid_i)
				begin
					state_q <= IDLE;
					bready_q <= 1'b0;
					rvalid_q <= 1'b1;
					err_q <= (m_axi_bresp_i != RESP_OKAY);
				end
			end
			READ_ADDR:
			begin
				if (m_axi_arready_i)
				begin
					state_q <= READ_DATA;
					arvalid_q <= 1'b0;
					rready_q <= 1'b1;
				end
			end
			READ_DATA:
			begin
				if (m_axi_rvalid_i)
				begin
					state_q <= IDLE;
					rready_q <= 1'b0;
					rvalid_q <= 1'b1;
					err_q <= (m_axi_rresp_i != RESP_OKAY);
				end
			end
			default:
				state_q <= IDLE;
			endcase
		end
	end

	// Request payload and read data capture
	always_ff @(posedge clk_i)
	begin
		if (state_q == IDLE && ext_d.req)
		begin
			addr_q <= ext_d.addr;
			wdata_q <= ext_d.wdata;
			be_q <= ext_d.be;
		end
		if (m_axi_rvalid_i && rready_q)
			rdata_q <= m_axi_rdata_i;
	end

	assign m_axi_awvalid_o = awvalid_q;
	assign m_axi_awaddr_o = addr_q;
	assign m_axi_wvalid_o = wvalid_q;
	assign m_axi_wdata_o = wdata_q;
	assign m_axi_wstrb_o = be_q;
	assign m_axi_bready_o = bready_q;
	assign m_axi_arvalid_o = arvalid_q;
	assign m_axi_araddr_o = addr_q;
	assign m_axi_rready_o = rready_q;

	assign ext_d.rvalid = rvalid_q;
	assign ext_d.rdata = rdata_q;
	assign ext_d.err = err_q;

endmodule

//--- hw/mem_req_if.sv
`timescale 1ns/1ns

interface mem_req_if import soc_mem_pkg::*; ();

	// Request side
	logic req;
	logic we;
	be_t be;
	addr_t addr;
	word_t wdata;

	// Grant and response side
	logic gnt;
	logic rvalid;
	word_t rdata;
	logic err;

	modport master (
		output req, we, be, addr, wdata,
		input gnt, rvalid, rdata, err
	);

	modport slave (
		input req, we, be, addr, wdata,
		output gnt, rvalid, rdata, err
	);

	// Response observer
	modport monitor (
		input rvalid, rdata, err
	);

endinterface

//--- hw/resp_merge.sv
`timescale 1ns/1ns

module resp_merge import soc_mem_pkg::*; (
	input logic clk_i,
	input logic resetn,
	input logic fetch_miss_i,
	mem_req_if.monitor tcm_i,
	mem_req_if.monitor tcm_d,
	mem_req_if.monitor ext_d,
	output logic instr_rvalid_o,
	output word_t instr_rdata_o,
	output logic instr_err_o,
	output logic data_rvalid_o,
	output word_t data_rdata_o,
	output logic data_err_o
);

	logic fetch_err_q;

	// Missed fetch answers one cycle after its grant
	always_ff @(posedge clk_i)
	begin
		if (!resetn)
			fetch_err_q <= 1'b0;
		else
			fetch_err_q <= fetch_miss_i;
	end

	assign instr_rvalid_o = tcm_i.rvalid | fetch_err_q;
	assign instr_err_o = fetch_err_q | (tcm_i.rvalid & tcm_i.err);
	assign instr_rdata_o = tcm_i.rvalid ? tcm_i.rdata : '0;

	// Sources never overlap on the data port
	assign data_rvalid_o = tcm_d.rvalid | ext_d.rvalid;
	assign data_err_o = (tcm_d.rvalid & tcm_d.err) | (ext_d.rvalid & ext_d.err);

	always_comb
	begin
		if (tcm_d.rvalid)
			data_rdata_o = tcm_d.rdata;
		else if (ext_d.rvalid)
			data_rdata_o = ext_d.rdata;
		else
			data_rdata_o = '0;
	end

endmodule

//--- hw/soc_mem_pkg.sv
package soc_mem_pkg;

	// Bus widths
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0] be_t;

	// Address bits 31:28
	typedef logic [3:0] region_t;

	// Tightly-coupled RAM lives here
	localparam region_t TCM_REGION = 4'd8;

	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY = 2'd0;
	localparam axi_resp_t RESP_SLVERR = 2'd2;

	// Outside data path FSM
	typedef enum logic [2:0] {
		IDLE,
		WRITE_ADDR_DATA,
		WRITE_RESP,
		READ_ADDR,
		READ_DATA
	} bridge_state_t;

endpackage

//--- hw/soc_mem_top.sv
`timescale 1ns/1ns

module soc_mem_top import soc_mem_pkg::*; #(
	parameter int TCM_DEPTH = 1024
) (
	input logic clk_i,
	input logic resetn,
	// Instruction port
	input logic instr_req_i,
	input addr_t instr_addr_i,
	output logic instr_gnt_o,
	output logic instr_rvalid_o,
	output word_t instr_rdata_o,
	output logic instr_err_o,
	// Data port
	input logic data_req_i,
	input logic data_we_i,
	input be_t data_be_i,
	input addr_t data_addr_i,
	input word_t data_wdata_i,
	output logic data_gnt_o,
	output logic data_rvalid_o,
	output word_t data_rdata_o,
	output logic data_err_o,
	// AXI4-Lite master
	output logic m_axi_awvalid_o,
	input logic m_axi_awready_i,
	output addr_t m_axi_awaddr_o,
	output logic m_axi_wvalid_o,
	input logic m_axi_wready_i,
	output word_t m_axi_wdata_o,
	output be_t m_axi_wstrb_o,
	input logic m_axi_bvalid_i,
	output logic m_axi_bready_o,
	input axi_resp_t m_axi_bresp_i,
	output logic m_axi_arvalid_o,
	input logic m_axi_arready_i,
	output addr_t m_axi_araddr_o,
	input logic m_axi_rvalid_i,
	output logic m_axi_rready_o,
	input word_t m_axi_rdata_i,
	input axi_resp_t m_axi_rresp_i
);

	logic bridge_idle;
	logic fetch_miss;

	mem_req_if tcm_i ();
	mem_req_if tcm_d ();
	mem_req_if ext_d ();

	addr_region_decode u_decode (
		.instr_req_i   (instr_req_i),
		.instr_addr_i  (instr_addr_i),
		.data_req_i    (data_req_i),
		.data_we_i     (data_we_i),
		.data_addr_i   (data_addr_i),
		.data_be_i     (data_be_i),
		.data_wdata_i  (data_wdata_i),
		.bridge_idle_i (bridge_idle),
		.instr_gnt_o   (instr_gnt_o),
		.data_gnt_o    (data_gnt_o),
		.fetch_miss_o  (fetch_miss),
		.tcm_i         (tcm_i),
		.tcm_d         (tcm_d),
		.ext_d         (ext_d)
	);

	tcm_ram #(
		.TCM_DEPTH (TCM_DEPTH)
	) u_tcm (
		.clk_i  (clk_i),
		.resetn (resetn),
		.tcm_i  (tcm_i),
		.tcm_d  (tcm_d)
	);

	data_axil_bridge u_bridge (
		.clk_i           (clk_i),
		.resetn          (resetn),
		.ext_d           (ext_d),
		.bridge_idle_o   (bridge_idle),
		.m_axi_awvalid_o (m_axi_awvalid_o),
		.m_axi_awready_i (m_axi_awready_i),
		.m_axi_awaddr_o  (m_axi_awaddr_o),
		.m_axi_wvalid_o  (m_axi_wvalid_o),
		.m_axi_wready_i  (m_axi_wready_i),
		.m_axi_wdata_o   (m_axi_wdata_o),
		.m_axi_wstrb_o   (m_axi_wstrb_o),
		.m_axi_bvalid_i  (m_axi_bvalid_i),
		.m_axi_bready_o  (m_axi_bready_o),
		.m_axi_bresp_i   (m_axi_bresp_i),
		.m_axi_arvalid_o (m_axi_arvalid_o),
		.m_axi_arready_i (m_axi_arready_i),
		.m_axi_araddr_o  (m_axi_araddr_o),
		.m_axi_rvalid_i  (m_axi_rvalid_i),
		.m_axi_rready_o  (m_axi_rready_o),
		.m_axi_rdata_i   (m_axi_rdata_i),
		.m_axi_rresp_i   (m_axi_rresp_i)
	);

	resp_merge u_merge (
		.clk_i          (clk_i),
		.resetn         (resetn),
		.fetch_miss_i   (fetch_miss),
		.tcm_i          (tcm_i),
		.tcm_d          (tcm_d),
		.ext_d          (ext_d),
		.instr_rvalid_o (instr_rvalid_o),
		.instr_rdata_o  (instr_rdata_o),
		.instr_err_o    (instr_err_o),
		.data_rvalid_o  (data_rvalid_o),
		.data_rdata_o   (data_rdata_o),
		.data_err_o     (data_err_o)
	);

endmodule

//--- hw/tcm_ram.sv
`timescale 1ns/1ns

module tcm_ram import soc_mem_pkg::*; #(
	parameter int TCM_DEPTH = 1024
) (
	input logic clk_i,
	input logic resetn,
	mem_req_if.slave tcm_i,
	mem_req_if.slave tcm_d
);

	localparam int IDX_W = $clog2(TCM_DEPTH);

	word_t mem [TCM_DEPTH];

	logic [IDX_W-1:0] i_idx;
	logic [IDX_W-1:0] d_idx;

	word_t i_rdata_q;
	word_t d_rdata_q;
	logic i_rvalid_q;
	logic d_rvalid_q;

	// Word index from the low address bits
	assign i_idx = tcm_i.addr[IDX_W+1:2];
	assign d_idx = tcm_d.addr[IDX_W+1:2];

	// Both ports take a request every cycle
	assign tcm_i.gnt = 1'b1;
	assign tcm_d.gnt = 1'b1;

	// Data port write with byte enables
	always_ff @(posedge clk_i)
	begin
		if (tcm_d.req && tcm_d.we)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (tcm_d.be[b])
					mem[d_idx][8*b +: 8] <= tcm_d.wdata[8*b +: 8];
			end
		end
	end

	// Registered reads
	always_ff @(posedge clk_i)
	begin
		if (tcm_i.req)
			i_rdata_q <= mem[i_idx];
		if (tcm_d.req)
			d_rdata_q <= mem[d_idx];
	end

	always_ff @(posedge clk_i)
	begin
		if (!resetn)
		begin
			i_rvalid_q <= 1'b0;
			d_rvalid_q <= 1'b0;
		end
		else
		begin
			i_rvalid_q <= tcm_i.req;
			d_rvalid_q <= tcm_d.req;
		end
	end

	assign tcm_i.rvalid = i_rvalid_q;
	assign tcm_i.rdata = i_rdata_q;
	assign tcm_i.err = 1'b0;

	assign tcm_d.rvalid = d_rvalid_q;
	assign tcm_d.rdata = d_rdata_q;
	assign tcm_d.err = 1'b0;

endmodule

//--- testbench/soc_mem_assert.sv
`timescale 1ns/1ns

module soc_mem_assert import soc_mem_pkg::*; (
	input logic clk_i,
	input logic resetn,
	input addr_t instr_addr_i,
	input logic instr_gnt_o,
	input logic instr_rvalid_o,
	input word_t instr_rdata_o,
	input logic instr_err_o,
	input addr_t data_addr_i,
	input logic data_gnt_o,
	input logic data_rvalid_o,
	input logic data_err_o,
	input logic m_axi_awvalid_o,
	input logic m_axi_awready_i,
	input addr_t m_axi_awaddr_o,
	input logic m_axi_wvalid_o,
	input logic m_axi_wready_i,
	input word_t m_axi_wdata_o,
	input be_t m_axi_wstrb_o,
	input logic m_axi_bready_o,
	input logic m_axi_arvalid_o,
	input logic m_axi_arready_i,
	input addr_t m_axi_araddr_o,
	input logic m_axi_rready_o
);

	int fail_count;
	logic ext_busy;

	// Outside access between its grant and its response
	always_ff @(posedge clk_i)
	begin
		if (!resetn)
			ext_busy <= 1'b0;
		else if (data_gnt_o && data_addr_i[31:28] != TCM_REGION)
			ext_busy <= 1'b1;
		else if (data_rvalid_o)
			ext_busy <= 1'b0;
	end

	a_reset_quiet: assert property (@(posedge clk_i) !resetn |=>
		!instr_rvalid_o && !data_rvalid_o && !instr_err_o && !data_err_o
		&& !m_axi_awvalid_o && !m_axi_wvalid_o && !m_axi_arvalid_o
		&& !m_axi_bready_o && !m_axi_rready_o)
		else begin $error("Response or AXI output high after reset"); fail_count++; end

	a_tcm_fetch: assert property (@(posedge clk_i) disable iff (!resetn)
		instr_gnt_o && instr_addr_i[31:28] == TCM_REGION |=> instr_rvalid_o && !instr_err_o)
		else begin $error("RAM fetch response not one cycle after grant"); fail_count++; end

	a_fetch_miss: assert property (@(posedge clk_i) disable iff (!resetn)
		instr_gnt_o && instr_addr_i[31:28] != TCM_REGION |=>
		instr_rvalid_o && instr_err_o && instr_rdata_o == 32'd0)
		else begin $error("Fetch outside the region without error response"); fail_count++; end

	a_tcm_data: assert property (@(posedge clk_i) disable iff (!resetn)
		data_gnt_o && data_addr_i[31:28] == TCM_REGION |=> data_rvalid_o && !data_err_o)
		else begin $error("RAM data response not one cycle after grant"); fail_count++; end

	a_aw_hold: assert property (@(posedge clk_i) disable iff (!resetn)
		m_axi_awvalid_o && !m_axi_awready_i |=> m_axi_awvalid_o && $stable(m_axi_awaddr_o))
		else begin $error("AW channel changed before awready"); fail_count++; end

	a_w_hold: assert property (@(posedge clk_i) disable iff (!resetn)
		m_axi_wvalid_o && !m_axi_wready_i |=>
		m_axi_wvalid_o && $stable(m_axi_wdata_o) && $stable(m_axi_wstrb_o))
		else begin $error("W channel changed before wready"); fail_count++; end

	a_ar_hold: assert property (@(posedge clk_i) disable iff (!resetn)
		m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o))
		else begin $error("AR channel changed before arready"); fail_count++; end

	a_no_grant_busy: assert property (@(posedge clk_i) disable iff (!resetn)
		ext_busy && !data_rvalid_o |-> !data_gnt_o)
		else begin $error("Data grant while an outside access is outstanding"); fail_count++; end

endmodule

bind soc_mem_top soc_mem_assert u_assert (
	.clk_i           (clk_i),
	.resetn          (resetn),
	.instr_addr_i    (instr_addr_i),
	.instr_gnt_o     (instr_gnt_o),
	.instr_rvalid_o  (instr_rvalid_o),
	.instr_rdata_o   (instr_rdata_o),
	.instr_err_o     (instr_err_o),
	.data_addr_i     (data_addr_i),
	.data_gnt_o      (data_gnt_o),
	.data_rvalid_o   (data_rvalid_o),
	.data_err_o      (data_err_o),
	.m_axi_awvalid_o (m_axi_awvalid_o),
	.m_axi_awready_i (m_axi_awready_i),
	.m_axi_awaddr_o  (m_axi_awaddr_o),
	.m_axi_wvalid_o  (m_axi_wvalid_o),
	.m_axi_wready_i  (m_axi_wready_i),
	.m_axi_wdata_o   (m_axi_wdata_o),
	.m_axi_wstrb_o   (m_axi_wstrb_o),
	.m_axi_bready_o  (m_axi_bready_o),
	.m_axi_arvalid_o (m_axi_arvalid_o),
	.m_axi_arready_i (m_axi_arready_i),
	.m_axi_araddr_o  (m_axi_araddr_o),
	.m_axi_rready_o  (m_axi_rready_o)
);

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD_NS = 20
) (
	output logic clk_o
);

	initial
	begin
		clk_o = 1'b0;
		forever
			#(PERIOD_NS / 2) clk_o = ~clk_o;
	end

endmodule

//--- testbench/tb_soc_mem.sv
`timescale 1ns/1ns

module tb_soc_mem import soc_mem_pkg::*; ();

	localparam int TIMEOUT = 200;

	logic clk;
	logic resetn;

	logic instr_req;
	addr_t instr_addr;
	logic instr_gnt;
	logic instr_rvalid;
	word_t instr_rdata;
	logic instr_err;

	logic data_req;
	logic data_we;
	be_t data_be;
	addr_t data_addr;
	word_t data_wdata;
	logic data_gnt;
	logic data_rvalid;
	word_t data_rdata;
	logic data_err;

	logic axi_awvalid;
	logic axi_awready;
	addr_t axi_awaddr;
	logic axi_wvalid;
	logic axi_wready;
	word_t axi_wdata;
	be_t axi_wstrb;
	logic axi_bvalid;
	logic axi_bready;
	axi_resp_t axi_bresp;
	logic axi_arvalid;
	logic axi_arready;
	addr_t axi_araddr;
	logic axi_rvalid;
	logic axi_rready;
	word_t axi_rdata;
	axi_resp_t axi_rresp;

	// AXI slave model state
	word_t slave_mem [addr_t];
	int aw_dly;
	int w_dly;
	int b_dly;
	int ar_dly;
	int r_dly;
	logic aw_done;
	logic w_done;
	logic ar_done;
	addr_t wr_addr;
	word_t wr_data;
	be_t wr_strb;
	addr_t rd_addr;
	addr_t seen_awaddr;
	be_t seen_wstrb;
	addr_t seen_araddr;

	// Responses in arrival order
	word_t instr_data_q [$];
	logic instr_err_q [$];
	word_t data_data_q [$];
	logic data_err_q [$];

	tb_clock_gen #(
		.PERIOD_NS (20)
	) u_clk (
		.clk_o (clk)
	);

	soc_mem_top dut0 (
		.clk_i           (clk),
		.resetn          (resetn),
		.instr_req_i     (instr_req),
		.instr_addr_i    (instr_addr),
		.instr_gnt_o     (instr_gnt),
		.instr_rvalid_o  (instr_rvalid),
		.instr_rdata_o   (instr_rdata),
		.instr_err_o     (instr_err),
		.data_req_i      (data_req),
		.data_we_i       (data_we),
		.data_be_i       (data_be),
		.data_addr_i     (data_addr),
		.data_wdata_i    (data_wdata),
		.data_gnt_o      (data_gnt),
		.data_rvalid_o   (data_rvalid),
		.data_rdata_o    (data_rdata),
		.data_err_o      (data_err),
		.m_axi_awvalid_o (axi_awvalid),
		.m_axi_awready_i (axi_awready),
		.m_axi_awaddr_o  (axi_awaddr),
		.m_axi_wvalid_o  (axi_wvalid),
		.m_axi_wready_i  (axi_wready),
		.m_axi_wdata_o   (axi_wdata),
		.m_axi_wstrb_o   (axi_wstrb),
		.m_axi_bvalid_i  (axi_bvalid),
		.m_axi_bready_o  (axi_bready),
		.m_axi_bresp_i   (axi_bresp),
		.m_axi_arvalid_o (axi_arvalid),
		.m_axi_arready_i (axi_arready),
		.m_axi_araddr_o  (axi_araddr),
		.m_axi_rvalid_i  (axi_rvalid),
		.m_axi_rready_o  (axi_rready),
		.m_axi_rdata_i   (axi_rdata),
		.m_axi_rresp_i   (axi_rresp)
	);

	function automatic word_t apply_strb(input word_t old_word, input word_t new_word,
		input be_t strb);
		word_t result;
		result = old_word;
		for (int b = 0; b < 4; b++)
		begin
			if (strb[b])
				result[8*b +: 8] = new_word[8*b +: 8];
		end
		return result;
	endfunction

	// Unwritten words read back as the inverted address
	function automatic word_t slave_word(input addr_t addr);
		if (slave_mem.exists(addr))
			return slave_mem[addr];
		return ~addr;
	endfunction

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("Verification failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_word(input string test, input word_t expected, input word_t actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch %s: expected %08h, actual %08h",
				test, expected, actual));
	endtask

	task automatic check_flag(input string test, input logic expected, input logic actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch %s: expected %b, actual %b",
				test, expected, actual));
	endtask

	task automatic data_issue(input logic we, input be_t be, input addr_t addr,
		input word_t wdata);
		int cycles;
		data_req <= 1'b1;
		data_we <= we;
		data_be <= be;
		data_addr <= addr;
		data_wdata <= wdata;
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				report_failure("Timeout while waiting for a data grant");
		end
		while (!data_gnt);
		data_req <= 1'b0;
	endtask

	task automatic data_collect(output word_t rdata, output logic err);
		int cycles;
		cycles = 0;
		while (data_data_q.size() == 0)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				report_failure("Timeout while waiting for a data response");
		end
		rdata = data_data_q.pop_front();
		err = data_err_q.pop_front();
	endtask

	task automatic data_access(input logic we, input be_t be, input addr_t addr,
		input word_t wdata, output word_t rdata, output logic err);
		data_issue(we, be, addr, wdata);
		data_collect(rdata, err);
	endtask

	// Leaves the request raised so fetches can follow back to back
	task automatic fetch_issue(input addr_t addr);
		int cycles;
		instr_req <= 1'b1;
		instr_addr <= addr;
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				report_failure("Timeout while waiting for an instruction grant");
		end
		while (!instr_gnt);
	endtask

	task automatic fetch_collect(output word_t rdata, output logic err);
		int cycles;
		cycles = 0;
		while (instr_data_q.size() == 0)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				report_failure("Timeout while waiting for an instruction response");
		end
		rdata = instr_data_q.pop_front();
		err = instr_err_q.pop_front();
	endtask

	// Responses taken at the falling edge, away from the driving edge
	always @(negedge clk)
	begin
		if (instr_rvalid)
		begin
			instr_data_q.push_back(instr_rdata);
			instr_err_q.push_back(instr_err);
		end
		if (data_rvalid)
		begin
			data_data_q.push_back(data_rdata);
			data_err_q.push_back(data_err);
		end
		if (dut0.u_assert.fail_count != 0)
			report_failure("A concurrent assertion on the DUT failed");
	end

	// AXI4-Lite slave with random ready and response delays
	initial
	begin
		axi_awready <= 1'b0;
		axi_wready <= 1'b0;
		axi_bvalid <= 1'b0;
		axi_bresp <= RESP_OKAY;
		axi_arready <= 1'b0;
		axi_rvalid <= 1'b0;
		axi_rdata <= '0;
		axi_rresp <= RESP_OKAY;
		aw_done <= 1'b0;
		w_done <= 1'b0;
		ar_done <= 1'b0;
		aw_dly <= 1;
		w_dly <= 2;
		b_dly <= 0;
		ar_dly <= 3;
		r_dly <= 1;
		forever
		begin
			@(posedge clk);
			axi_awready <= 1'b0;
			axi_wready <= 1'b0;
			axi_arready <= 1'b0;
			if (axi_awvalid && !axi_awready)
			begin
				if (aw_dly == 0)
					axi_awready <= 1'b1;
				else
					aw_dly <= aw_dly - 1;
			end
			if (axi_awvalid && axi_awready)
			begin
				aw_done <= 1'b1;
				wr_addr <= axi_awaddr;
				seen_awaddr <= axi_awaddr;
				aw_dly <= $urandom_range(3);
			end
			if (axi_wvalid && !axi_wready)
			begin
				if (w_dly == 0)
					axi_wready <= 1'b1;
				else
					w_dly <= w_dly - 1;
			end
			if (axi_wvalid && axi_wready)
			begin
				w_done <= 1'b1;
				wr_data <= axi_wdata;
				wr_strb <= axi_wstrb;
				seen_wstrb <= axi_wstrb;
				w_dly <= $urandom_range(3);
			end
			if (aw_done && w_done && !axi_bvalid)
			begin
				if (b_dly == 0)
				begin
					axi_bvalid <= 1'b1;
					axi_bresp <= (wr_addr[31:28] == 4'hf) ? RESP_SLVERR : RESP_OKAY;
					if (wr_addr[31:28] != 4'hf)
						slave_mem[wr_addr] = apply_strb(slave_word(wr_addr), wr_data, wr_strb);
				end
				else
					b_dly <= b_dly - 1;
			end
			if (axi_bvalid && axi_bready)
			begin
				axi_bvalid <= 1'b0;
				aw_done <= 1'b0;
				w_done <= 1'b0;
				b_dly <= $urandom_range(3);
			end
			if (axi_arvalid && !axi_arready)
			begin
				if (ar_dly == 0)
					axi_arready <= 1'b1;
				else
					ar_dly <= ar_dly - 1;
			end
			if (axi_arvalid && axi_arready)
			begin
				ar_done <= 1'b1;
				rd_addr <= axi_araddr;
				seen_araddr <= axi_araddr;
				ar_dly <= $urandom_range(3);
			end
			if (ar_done && !axi_rvalid)
			begin
				if (r_dly == 0)
				begin
					axi_rvalid <= 1'b1;
					axi_rdata <= slave_word(rd_addr);
					axi_rresp <= (rd_addr[31:28] == 4'hf) ? RESP_SLVERR : RESP_OKAY;
				end
				else
					r_dly <= r_dly - 1;
			end
			if (axi_rvalid && axi_rready)
			begin
				axi_rvalid <= 1'b0;
				ar_done <= 1'b0;
				r_dly <= $urandom_range(3);
			end
		end
	end

	initial
	begin
		word_t rdata;
		logic err;
		addr_t addr;
		word_t wdata;
		void'($urandom(32'h2f30_bc2c));
		resetn <= 1'b0;
		instr_req <= 1'b0;
		instr_addr <= '0;
		data_req <= 1'b0;
		data_we <= 1'b0;
		data_be <= '0;
		data_addr <= '0;
		data_wdata <= '0;
		repeat (8) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);

		// Partial write into the RAM region
		data_access(1'b1, 4'hf, 32'h8000_0010, 32'h1122_3344, rdata, err);
		data_access(1'b1, 4'b0101, 32'h8000_0010, 32'haabb_ccdd, rdata, err);
		data_access(1'b0, 4'hf, 32'h8000_0010, '0, rdata, err);
		check_word("tcm byte write", 32'h11bb_33dd, rdata);
		check_flag("tcm read err", 1'b0, err);

		// Three fetches back to back
		data_access(1'b1, 4'hf, 32'h8000_0020, 32'h0000_0013, rdata, err);
		data_access(1'b1, 4'hf, 32'h8000_0024, 32'h0040_0093, rdata, err);
		fetch_issue(32'h8000_0010);
		fetch_issue(32'h8000_0020);
		fetch_issue(32'h8000_0024);
		instr_req <= 1'b0;
		fetch_collect(rdata, err);
		check_word("tcm fetch 0", 32'h11bb_33dd, rdata);
		check_flag("tcm fetch 0 err", 1'b0, err);
		fetch_collect(rdata, err);
		check_word("tcm fetch 1", 32'h0000_0013, rdata);
		fetch_collect(rdata, err);
		check_word("tcm fetch 2", 32'h0040_0093, rdata);

		// Outside write and read
		data_access(1'b1, 4'hf, 32'h2000_0040, 32'hcafe_f00d, rdata, err);
		check_flag("axi write err", 1'b0, err);
		check_word("axi awaddr", 32'h2000_0040, seen_awaddr);
		data_access(1'b1, 4'b0011, 32'h2000_0040, 32'h1234_5678, rdata, err);
		check_word("axi wstrb", 32'h0000_0003, {28'd0, seen_wstrb});
		data_access(1'b0, 4'hf, 32'h2000_0040, '0, rdata, err);
		check_word("axi read", 32'hcafe_5678, rdata);
		check_flag("axi read err", 1'b0, err);
		check_word("axi araddr", 32'h2000_0040, seen_araddr);

		// Region 15 answers SLVERR
		data_access(1'b1, 4'hf, 32'hf000_0000, 32'h0bad_0bad, rdata, err);
		check_flag("slave error write", 1'b1, err);
		data_access(1'b0, 4'hf, 32'hf000_0004, '0, rdata, err);
		check_flag("slave error read", 1'b1, err);

		fetch_issue(32'h0000_0100);
		instr_req <= 1'b0;
		fetch_collect(rdata, err);
		check_flag("fetch miss err", 1'b1, err);
		check_word("fetch miss data", 32'h0000_0000, rdata);

		// RAM read raised while the bridge is still busy
		data_issue(1'b1, 4'hf, 32'h2000_0080, 32'h5a5a_0001);
		data_issue(1'b0, 4'hf, 32'h8000_0010, '0);
		data_collect(rdata, err);
		check_flag("overlap axi err", 1'b0, err);
		data_collect(rdata, err);
		check_word("overlap tcm read", 32'h11bb_33dd, rdata);

		for (int i = 0; i < 12; i++)
		begin
			addr = 32'h2000_0100 | ($urandom_range(7) << 2);
			wdata = $urandom();
			data_access(1'b1, 4'hf, addr, wdata, rdata, err);
			data_access(1'b0, 4'hf, addr, '0, rdata, err);
			check_word("random axi read", wdata, rdata);
		end

		repeat (2) @(posedge clk);
		if (dut0.u_assert.fail_count == 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
			report_failure("A concurrent assertion on the DUT failed");
	end

endmodule
